// File: rtl/tcb_lite_mon_macros.svh
`ifndef TCB_LITE_MON_MACROS_SVH
`define TCB_LITE_MON_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////////////////////////

// address width
`define TCB_LITE_MON_AW 32
// data width, byte enable is DW/8 bits wide
`define TCB_LITE_MON_DW 32

//////////////////////////////////////////////////////////////////////
// monitor timing and storage
//////////////////////////////////////////////////////////////////////

// response delay in cycles after the transfer, must be at least 1
`define TCB_LITE_MON_DLY 1
// width of the saturating idle and back-pressure counters
`define TCB_LITE_MON_CW 16
// pending FIFO holds every request still waiting for its response
`define TCB_LITE_MON_PEND_DEPTH (`TCB_LITE_MON_DLY + 1)
// record FIFO between the merger and the host
`define TCB_LITE_MON_REC_DEPTH 8

`endif

// File: rtl/tcb_lite_mon_pkg.sv
`include "tcb_lite_mon_macros.svh"

package tcb_lite_mon_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus side types
    //////////////////////////////////////////////////////////////////////

    // request as seen on the bus at the transfer edge
    typedef struct packed {
        // write enable, low for a read
        logic                          wen;
        // byte address
        logic [`TCB_LITE_MON_AW-1:0]   adr;
        // write data
        logic [`TCB_LITE_MON_DW-1:0]   wdt;
        // byte enables, one per data byte
        logic [`TCB_LITE_MON_DW/8-1:0] ben;
    } mon_req_t;

    // response, valid DLY cycles after the transfer
    typedef struct packed {
        // read data
        logic [`TCB_LITE_MON_DW-1:0] rdt;
        // error flag
        logic                        err;
    } mon_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // monitor internal types
    //////////////////////////////////////////////////////////////////////

    // saturating cycle count
    typedef logic [`TCB_LITE_MON_CW-1:0] mon_cnt_t;

    // request waiting for its response
    typedef struct packed {
        // captured request
        mon_req_t req;
        // idle cycles before the transfer
        mon_cnt_t idl;
        // back-pressure cycles before the transfer
        mon_cnt_t bpr;
    } mon_pend_t;

    // one complete transfer record
    typedef struct packed {
        // request and its counts
        mon_pend_t pend;
        // response paired with the request
        mon_rsp_t  rsp;
    } mon_rec_t;

endpackage

// File: rtl/tcb_lite_req_sampler.sv
`timescale 1ns/1ps

module tcb_lite_req_sampler (
    // monitor clock and synchronous reset
    input  logic                        mon,
    input  logic                        rst_n,
    // observed bus handshake
    input  logic                        vld,
    input  logic                        rdy,
    // observed bus request
    input  tcb_lite_mon_pkg::mon_req_t  req,
    // pending FIFO write side
    output logic                        pend_push,
    output tcb_lite_mon_pkg::mon_pend_t pend_data
);

    import tcb_lite_mon_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // transfer detection
    //////////////////////////////////////////////////////////////////////

    // transfer at this edge
    logic     trn;
    // idle cycle, bus ready but no request
    logic     idl_cyc;
    // back-pressure cycle, request waiting for ready
    logic     bpr_cyc;

    // counters, hold the counts accumulated since the last transfer
    mon_cnt_t idl;
    mon_cnt_t bpr;

    assign trn     = vld & rdy;
    assign idl_cyc = ~vld &  rdy;
    assign bpr_cyc =  vld & ~rdy;

    //////////////////////////////////////////////////////////////////////
    // idle and back-pressure counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge mon) begin
        if (!rst_n) begin
            idl <= '0;
            bpr <= '0;
        end else if (trn) begin
            // both counts restart at the transfer edge
            idl <= '0;
            bpr <= '0;
        end else begin
            // saturate at all ones
            if (idl_cyc && (idl != '1)) begin
                idl <= idl + 1'b1;
            end
            if (bpr_cyc && (bpr != '1)) begin
                bpr <= bpr + 1'b1;
            end
            // vld and rdy both low leaves both counts as they are
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pending entry
    //////////////////////////////////////////////////////////////////////

    // push straight from the transfer condition
    assign pend_push = trn;

    // counts are the values before the clear at this same edge
    assign pend_data = '{
        req: req,
        idl: idl,
        bpr: bpr
    };

endmodule

// File: rtl/tcb_lite_mon_fifo.sv
`timescale 1ns/1ps

module tcb_lite_mon_fifo #(
    // entry type
    parameter type         payload_t = logic,
    // number of entries
    parameter int unsigned DEPTH     = 2
) (
    input  logic     mon,
    input  logic     rst_n,
    // write side
    input  logic     push,
    input  payload_t wdata,
    // read side, rdata shows the head entry
    input  logic     pop,
    output payload_t rdata,
    // status
    output logic     full,
    output logic     empty
);

    // pointer width, at least one bit for a single entry buffer
    localparam int unsigned ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // occupancy width, must hold the value DEPTH
    localparam int unsigned cnt_w = $clog2(DEPTH + 1);

    // storage
    payload_t           mem [DEPTH];

    // circular pointers and occupancy
    logic [ptr_w-1:0]   wptr;
    logic [ptr_w-1:0]   rptr;
    logic [cnt_w-1:0]   cnt;

    // qualified strobes, push when full and pop when empty are dropped
    logic               push_ok;
    logic               pop_ok;

    assign full    = (cnt == cnt_w'(DEPTH));
    assign empty   = (cnt == '0);
    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge mon) begin
        if (!rst_n) begin
            wptr <= '0;
            rptr <= '0;
            cnt  <= '0;
        end else begin
            // wrap explicitly, depth need not be a power of two
            if (push_ok) begin
                wptr <= (wptr == ptr_w'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (pop_ok) begin
                rptr <= (rptr == ptr_w'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({push_ok, pop_ok})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge mon) begin
        if (push_ok) begin
            mem[wptr] <= wdata;
        end
    end

    // first word fall through
    assign rdata = mem[rptr];

endmodule

// File: rtl/tcb_lite_rsp_merger.sv
`timescale 1ns/1ps

`include "tcb_lite_mon_macros.svh"

module tcb_lite_rsp_merger (
    input  logic                        mon,
    input  logic                        rst_n,
    // observed bus handshake and response
    input  logic                        vld,
    input  logic                        rdy,
    input  tcb_lite_mon_pkg::mon_rsp_t  rsp,
    // pending FIFO read side
    output logic                        pend_pop,
    input  tcb_lite_mon_pkg::mon_pend_t pend_data,
    // record FIFO write side
    output logic                        rec_push,
    output tcb_lite_mon_pkg::mon_rec_t  rec_data,
    input  logic                        rec_full,
    // sticky record loss flag
    output logic                        ovf
);

    // transfer at this edge
    logic                         trn;
    // transfer bits delayed by 1..DLY cycles
    logic [`TCB_LITE_MON_DLY-1:0] trn_dly;
    // response of a past transfer is on the bus now
    logic                         rsp_due;

    assign trn     = vld & rdy;
    assign rsp_due = trn_dly[`TCB_LITE_MON_DLY-1];

    //////////////////////////////////////////////////////////////////////
    // transfer delay line
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge mon) begin
        if (!rst_n) begin
            trn_dly <= '0;
        end else begin
            trn_dly[0] <= trn;
            // loop body is skipped for a single cycle delay
            for (int i = 1; i < `TCB_LITE_MON_DLY; i++) begin
                trn_dly[i] <= trn_dly[i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pairing and record write
    //////////////////////////////////////////////////////////////////////

    // pending head always belongs to the oldest transfer in flight
    assign pend_pop = rsp_due;
    // record is lost when the host lets the queue fill
    assign rec_push = rsp_due & ~rec_full;

    // live response joined with the stored request
    assign rec_data = '{
        pend: pend_data,
        rsp:  rsp
    };

    // overflow stays set until reset
    always_ff @(posedge mon) begin
        if (!rst_n) begin
            ovf <= 1'b0;
        end else if (rsp_due && rec_full) begin
            ovf <= 1'b1;
        end
    end

endmodule

// File: rtl/tcb_lite_monitor.sv
`timescale 1ns/1ps

`include "tcb_lite_mon_macros.svh"

module tcb_lite_monitor (
    input  logic                       mon,
    input  logic                       rst_n,
    // observed bus, never driven
    input  logic                       vld,
    input  logic                       rdy,
    input  tcb_lite_mon_pkg::mon_req_t req,
    input  tcb_lite_mon_pkg::mon_rsp_t rsp,
    // host record port
    input  logic                       rec_pop,
    output logic                       rec_vld,
    output tcb_lite_mon_pkg::mon_rec_t rec,
    // sticky overflow
    output logic                       ovf
);

    import tcb_lite_mon_pkg::*;

    // sampler to pending FIFO
    logic      pend_push;
    mon_pend_t pend_wdata;

    // pending FIFO to merger
    logic      pend_pop;
    mon_pend_t pend_rdata;

    // merger to record FIFO
    logic      rec_push;
    mon_rec_t  rec_data;
    logic      rec_full;
    logic      rec_empty;

    //////////////////////////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////////////////////////

    tcb_lite_req_sampler sampler_i (
        .mon       (mon),
        .rst_n     (rst_n),
        .vld       (vld),
        .rdy       (rdy),
        .req       (req),
        .pend_push (pend_push),
        .pend_data (pend_wdata)
    );

    // sized one above the transfers in flight, so it never fills
    tcb_lite_mon_fifo #(
        .payload_t (mon_pend_t),
        .DEPTH     (`TCB_LITE_MON_PEND_DEPTH)
    ) pend_fifo_i (
        .mon   (mon),
        .rst_n (rst_n),
        .push  (pend_push),
        .wdata (pend_wdata),
        .pop   (pend_pop),
        .rdata (pend_rdata),
        .full  (),
        .empty ()
    );

    //////////////////////////////////////////////////////////////////////
    // response side and host queue
    //////////////////////////////////////////////////////////////////////

    tcb_lite_rsp_merger merger_i (
        .mon       (mon),
        .rst_n     (rst_n),
        .vld       (vld),
        .rdy       (rdy),
        .rsp       (rsp),
        .pend_pop  (pend_pop),
        .pend_data (pend_rdata),
        .rec_push  (rec_push),
        .rec_data  (rec_data),
        .rec_full  (rec_full),
        .ovf       (ovf)
    );

    tcb_lite_mon_fifo #(
        .payload_t (mon_rec_t),
        .DEPTH     (`TCB_LITE_MON_REC_DEPTH)
    ) rec_fifo_i (
        .mon   (mon),
        .rst_n (rst_n),
        .push  (rec_push),
        .wdata (rec_data),
        .pop   (rec_pop),
        .rdata (rec),
        .full  (rec_full),
        .empty (rec_empty)
    );

    // head is valid whenever the queue holds a record
    assign rec_vld = ~rec_empty;

endmodule

// File: sim/tcb_lite_monitor_tb.sv
`timescale 1ns/1ps

`include "tcb_lite_mon_macros.svh"

module tcb_lite_monitor_tb;

    import tcb_lite_mon_pkg::*;

    // cycles any single wait may take before the run is abandoned
    localparam int unsigned wait_max = 64;

    // DUT ports
    logic     mon;
    logic     rst_n;
    logic     vld;
    logic     rdy;
    mon_req_t req;
    mon_rsp_t rsp;
    logic     rec_pop;
    logic     rec_vld;
    mon_rec_t rec;
    logic     ovf;

    // xorshift state
    logic [31:0] rng;

    // reference model counts before the next transfer
    logic [`TCB_LITE_MON_CW-1:0] idl_m;
    logic [`TCB_LITE_MON_CW-1:0] bpr_m;
    logic                        ovf_m;
    // index of the coming clock edge
    int unsigned                 cyc;
    // transfers waiting for their response and the edge each is due at
    int unsigned                 due_q[$];
    mon_rec_t                    fly_q[$];
    // expected content of the record FIFO from the head on
    mon_rec_t                    exp_q[$];

    tcb_lite_monitor dut_i (
        .mon     (mon),
        .rst_n   (rst_n),
        .vld     (vld),
        .rdy     (rdy),
        .req     (req),
        .rsp     (rsp),
        .rec_pop (rec_pop),
        .rec_vld (rec_vld),
        .rec     (rec),
        .ovf     (ovf)
    );

    always #4 mon = ~mon;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x   = rng;
        x   = x ^ (x << 13);
        x   = x ^ (x >> 17);
        x   = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // random word aligned request
    function automatic mon_req_t make_req();
        mon_req_t    r;
        logic [31:0] a;
        a     = xorshift();
        r.wen = a[31];
        r.adr = {a[29:0], 2'b00};
        r.wdt = xorshift();
        r.ben = a[7:4];
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic compare_value(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %0h, expected %0h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // one bus cycle with inputs set 1 ns after an edge and the model stepped with it
    task automatic bus_cycle(input logic v, input logic r, input mon_req_t rq,
                             input logic pop);
        mon_rec_t    t;
        int unsigned sz0;
        logic        due;
        vld     = v;
        rdy     = r;
        req     = rq;
        rec_pop = pop;
        due     = (due_q.size() != 0) && (due_q[0] == cyc);
        // response of an older transfer or random junk
        if (due) begin
            rsp = fly_q[0].rsp;
        end else begin
            rsp.rdt = xorshift();
            rsp.err = rng[3];
        end
        // record FIFO full and empty judged before the edge
        sz0 = exp_q.size();
        if (pop && (sz0 != 0)) begin
            void'(exp_q.pop_front());
        end
        if (due) begin
            if (sz0 < `TCB_LITE_MON_REC_DEPTH) begin
                exp_q.push_back(fly_q[0]);
            end else begin
                ovf_m = 1'b1;
            end
            void'(due_q.pop_front());
            void'(fly_q.pop_front());
        end
        // counting rules
        if (v && r) begin
            t.pend.req = rq;
            t.pend.idl = idl_m;
            t.pend.bpr = bpr_m;
            t.rsp.rdt  = xorshift();
            t.rsp.err  = t.rsp.rdt[31];
            due_q.push_back(cyc + `TCB_LITE_MON_DLY);
            fly_q.push_back(t);
            idl_m = '0;
            bpr_m = '0;
        end else if (!v && r && (idl_m != '1)) begin
            idl_m = idl_m + 1'b1;
        end else if (v && !r && (bpr_m != '1)) begin
            bpr_m = bpr_m + 1'b1;
        end
        @(posedge mon);
        #1;
        cyc = cyc + 1;
        compare_value("rec_vld", 256'(rec_vld), 256'(exp_q.size() != 0));
        compare_value("ovf", 256'(ovf), 256'(ovf_m));
    endtask

    // quiet bus with vld and rdy both low
    task automatic quiet_cycles(input int n);
        repeat (n) bus_cycle(1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic wait_rec_vld();
        int unsigned n;
        n = 0;
        while (!rec_vld) begin
            if (n == wait_max) begin
                abort_run("timeout: rec_vld never rose");
            end
            bus_cycle(1'b0, 1'b0, '0, 1'b0);
            n = n + 1;
        end
    endtask

    task automatic compare_head();
        compare_value("rec.pend.req", 256'(rec.pend.req), 256'(exp_q[0].pend.req));
        compare_value("rec.pend.idl", 256'(rec.pend.idl), 256'(exp_q[0].pend.idl));
        compare_value("rec.pend.bpr", 256'(rec.pend.bpr), 256'(exp_q[0].pend.bpr));
        compare_value("rec.rsp.rdt", 256'(rec.rsp.rdt), 256'(exp_q[0].rsp.rdt));
        compare_value("rec.rsp.err", 256'(rec.rsp.err), 256'(exp_q[0].rsp.err));
    endtask

    // pop every record still expected in transfer order
    task automatic drain_records();
        while ((exp_q.size() != 0) || (due_q.size() != 0)) begin
            wait_rec_vld();
            compare_head();
            bus_cycle(1'b0, 1'b0, '0, 1'b1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic after_reset();
        compare_value("rec_vld", 256'(rec_vld), 256'(0));
        compare_value("ovf", 256'(ovf), 256'(0));
    endtask

    task automatic idle_gaps();
        int gap [4] = '{1, 4, 7, 0};
        foreach (gap[i]) begin
            repeat (gap[i]) bus_cycle(1'b0, 1'b1, '0, 1'b0);
            bus_cycle(1'b1, 1'b1, make_req(), 1'b0);
            wait_rec_vld();
            compare_value("rec.pend.idl", 256'(rec.pend.idl), 256'(gap[i]));
            compare_value("rec.pend.bpr", 256'(rec.pend.bpr), 256'(0));
            drain_records();
        end
    endtask

    task automatic back_pressure_counts();
        int       stall [2] = '{2, 5};
        mon_req_t r;
        foreach (stall[i]) begin
            r = make_req();
            // quiet cycles in between must not count
            quiet_cycles(3);
            repeat (2) bus_cycle(1'b0, 1'b1, '0, 1'b0);
            quiet_cycles(2);
            repeat (stall[i]) bus_cycle(1'b1, 1'b0, r, 1'b0);
            bus_cycle(1'b1, 1'b1, r, 1'b0);
            wait_rec_vld();
            compare_value("rec.pend.idl", 256'(rec.pend.idl), 256'(2));
            compare_value("rec.pend.bpr", 256'(rec.pend.bpr), 256'(stall[i]));
            drain_records();
        end
    endtask

    task automatic back_to_back();
        repeat (6) bus_cycle(1'b1, 1'b1, make_req(), 1'b0);
        quiet_cycles(1);
        drain_records();
    endtask

    task automatic record_overflow();
        // two more transfers than the record FIFO holds and no pops
        repeat (`TCB_LITE_MON_REC_DEPTH + 2) bus_cycle(1'b1, 1'b1, make_req(), 1'b0);
        // the last two records are lost and ovf rises while the first ones drain
        drain_records();
    endtask

    task automatic idle_saturation();
        repeat (70000) bus_cycle(1'b0, 1'b1, '0, 1'b0);
        bus_cycle(1'b1, 1'b1, make_req(), 1'b0);
        wait_rec_vld();
        compare_value("rec.pend.idl", 256'(rec.pend.idl), 256'(16'hffff));
        drain_records();
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        mon     = 1'b0;
        rst_n   = 1'b0;
        vld     = 1'b0;
        rdy     = 1'b0;
        req     = '0;
        rsp     = '0;
        rec_pop = 1'b0;
        rng     = 32'h4829_b055;
        idl_m   = '0;
        bpr_m   = '0;
        ovf_m   = 1'b0;
        cyc     = 0;
        repeat (8) @(posedge mon);
        #1;
        rst_n = 1'b1;
        after_reset();
        idle_gaps();
        back_pressure_counts();
        back_to_back();
        record_overflow();
        idle_saturation();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tcb_lite_monitor.f
+incdir+rtl
rtl/tcb_lite_mon_pkg.sv
rtl/tcb_lite_req_sampler.sv
rtl/tcb_lite_mon_fifo.sv
rtl/tcb_lite_rsp_merger.sv
rtl/tcb_lite_monitor.sv
sim/tcb_lite_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the TCB-Lite monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f tcb_lite_monitor.f --top-module tcb_lite_monitor_tb \
        -o tcb_lite_monitor_tb; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tcb_lite_monitor_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
